//--- hdl/tangcart_pkg.sv
`default_nettype none

package tangcart_pkg;

	// ----------------------------------------------------------------------
	// bus sizes
	// ----------------------------------------------------------------------
	localparam int addr_w = 16;
	localparam int data_w = 8;
	// offset inside one 16 KB page
	localparam int page_offset_w = 14;
	localparam int num_pages = 4;

	// ----------------------------------------------------------------------
	// memory mapper
	// ----------------------------------------------------------------------
	// ports fch..ffh select pages 0..3
	localparam logic [7:0] mapper_port_base = 8'hfc;
	// segments after reset, index is the page
	localparam logic [num_pages-1:0][1:0] reset_seg = {2'd0, 2'd1, 2'd2, 2'd3};
	localparam int default_seg_bits = 3;
	localparam int default_mem_latency = 4;

	// one bus address word, memory or i/o decode
	typedef union packed {
		struct packed {
			logic [1:0] page;
			logic [page_offset_w-1:0] offset;
		} mem;
		struct packed {
			logic [7:0] unused;
			logic [7:0] port;
		} io;
	} bus_addr_u;

endpackage

`default_nettype wire

//--- hdl/reset_sync.sv
`default_nettype none

module reset_sync (
	input  logic clk,
	input  logic n_treset,
	output logic w_n_reset,
	output logic twait
);

	logic [3:0] ff_reset_sr;
	logic [3:0] ff_wait_count;

	// ----------------------------------------------------------------------
	// reset synchroniser
	// ----------------------------------------------------------------------
	// any low sample in the window keeps reset asserted
	always_ff @(posedge clk) begin
		ff_reset_sr <= {ff_reset_sr[2:0], n_treset};
		// released one cycle after four clean high samples
		w_n_reset <= &ff_reset_sr;
	end

	// ----------------------------------------------------------------------
	// power-up wait
	// ----------------------------------------------------------------------
	// twait held through reset and 16 cycles after it
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_wait_count <= '0;
			twait <= 1'b1;
		end else if (ff_wait_count == 4'hf) begin
			// wait over, cpu may run
			twait <= 1'b0;
		end else begin
			ff_wait_count <= ff_wait_count + 4'd1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/msx_bus_slave.sv
`default_nettype none

module msx_bus_slave (
	input  logic clk,
	input  logic w_n_reset,
	input  logic n_tsltsl,
	input  logic n_tmerq,
	input  logic n_tiorq,
	input  logic n_trd,
	input  logic n_twr,
	input  logic [tangcart_pkg::addr_w-1:0] ta,
	input  logic [tangcart_pkg::data_w-1:0] td_in,
	output logic [tangcart_pkg::data_w-1:0] td_out,
	output logic td_oe,
	output tangcart_pkg::bus_addr_u bus_address,
	output logic [tangcart_pkg::data_w-1:0] bus_write_data,
	output logic bus_read,
	output logic bus_write,
	output logic bus_io,
	output logic bus_memory,
	input  logic bus_read_ready,
	input  logic [tangcart_pkg::data_w-1:0] bus_read_data
);

	// bit positions in the strobe vector
	localparam int s_wr = 0;
	localparam int s_rd = 1;
	localparam int s_iorq = 2;
	localparam int s_merq = 3;
	localparam int s_sltsl = 4;

	logic [4:0] ff_sync1;
	logic [4:0] ff_sync2;
	logic ff_rd_d;
	logic ff_wr_d;
	logic rd_fall;
	logic wr_fall;
	logic mem_sel;
	logic io_sel;

	// ----------------------------------------------------------------------
	// strobe synchroniser
	// ----------------------------------------------------------------------
	// idle high so reset never looks like a falling edge
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_sync1 <= '1;
			ff_sync2 <= '1;
			ff_rd_d <= 1'b1;
			ff_wr_d <= 1'b1;
		end else begin
			ff_sync1 <= {n_tsltsl, n_tmerq, n_tiorq, n_trd, n_twr};
			ff_sync2 <= ff_sync1;
			ff_rd_d <= ff_sync2[s_rd];
			ff_wr_d <= ff_sync2[s_wr];
		end
	end

	// falling edges of the synchronised rd and wr
	assign rd_fall = ff_rd_d & ~ff_sync2[s_rd];
	assign wr_fall = ff_wr_d & ~ff_sync2[s_wr];
	// memory needs our slot, i/o ignores the slot select
	assign mem_sel = ~ff_sync2[s_sltsl] & ~ff_sync2[s_merq];
	assign io_sel = ~ff_sync2[s_iorq];

	// ----------------------------------------------------------------------
	// access pulses
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			bus_read <= 1'b0;
			bus_write <= 1'b0;
			bus_io <= 1'b0;
			bus_memory <= 1'b0;
		end else begin
			bus_read <= rd_fall & (mem_sel | io_sel);
			bus_write <= wr_fall & (mem_sel | io_sel);
			// kind of access, held until the next edge
			if (rd_fall | wr_fall) begin
				bus_io <= io_sel;
				bus_memory <= mem_sel & ~io_sel;
			end
		end
	end

	// address and write data captured with the pulse
	always_ff @(posedge clk) begin
		if (rd_fall | wr_fall) begin
			bus_address <= ta;
			bus_write_data <= td_in;
		end
	end

	// ----------------------------------------------------------------------
	// read data to the cpu
	// ----------------------------------------------------------------------
	// drive td until the cpu ends the read
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			td_oe <= 1'b0;
		end else if (bus_read_ready) begin
			td_oe <= 1'b1;
		end else if (ff_sync2[s_rd]) begin
			td_oe <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (bus_read_ready) begin
			td_out <= bus_read_data;
		end
	end

endmodule

`default_nettype wire

//--- hdl/mapper_regs.sv
`default_nettype none

module mapper_regs #(
	parameter int seg_bits = tangcart_pkg::default_seg_bits
) (
	input  logic clk,
	input  logic w_n_reset,
	input  tangcart_pkg::bus_addr_u bus_address,
	input  logic [tangcart_pkg::data_w-1:0] bus_write_data,
	input  logic bus_read,
	input  logic bus_write,
	input  logic bus_io,
	input  logic bus_memory,
	output logic bus_read_ready,
	output logic [tangcart_pkg::data_w-1:0] bus_read_data,
	output logic mem_rd,
	output logic mem_wr,
	output logic [seg_bits+tangcart_pkg::page_offset_w-1:0] mem_address,
	output logic [tangcart_pkg::data_w-1:0] mem_wdata,
	input  logic busy,
	input  logic [tangcart_pkg::data_w-1:0] mem_rdata,
	input  logic mem_rdata_en
);

	logic [seg_bits-1:0] ff_seg [tangcart_pkg::num_pages];
	logic port_hit;
	logic [1:0] port_page;
	logic mem_access;
	logic ff_io_ready;
	logic [tangcart_pkg::data_w-1:0] ff_io_data;
	logic ff_req_rd;
	logic ff_req_wr;

	// ports fch..ffh, low two bits pick the page
	assign port_hit = bus_io &&
		(bus_address.io.port[7:2] == tangcart_pkg::mapper_port_base[7:2]);
	assign port_page = bus_address.io.port[1:0];
	assign mem_access = bus_memory & (bus_read | bus_write);

	// ----------------------------------------------------------------------
	// segment registers
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			for (int i = 0; i < tangcart_pkg::num_pages; i++) begin
				ff_seg[i] <= seg_bits'(tangcart_pkg::reset_seg[i]);
			end
		end else if (bus_write && port_hit) begin
			// only the implemented segment bits are kept
			ff_seg[port_page] <= bus_write_data[seg_bits-1:0];
		end
	end

	// port read answers one cycle later
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_io_ready <= 1'b0;
		end else begin
			ff_io_ready <= bus_read & port_hit;
		end
	end

	// missing upper segment bits read back as ones
	always_ff @(posedge clk) begin
		if (bus_read && port_hit) begin
			ff_io_data <= {{(tangcart_pkg::data_w-seg_bits){1'b1}}, ff_seg[port_page]};
		end
	end

	// ----------------------------------------------------------------------
	// memory request
	// ----------------------------------------------------------------------
	// request pending until the ram is idle
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_req_rd <= 1'b0;
			ff_req_wr <= 1'b0;
		end else if (mem_access) begin
			ff_req_rd <= bus_read;
			ff_req_wr <= bus_write;
		end else if (mem_rd || mem_wr) begin
			ff_req_rd <= 1'b0;
			ff_req_wr <= 1'b0;
		end
	end

	// cpu page replaced by its segment
	always_ff @(posedge clk) begin
		if (mem_access) begin
			mem_address <= {ff_seg[bus_address.mem.page], bus_address.mem.offset};
			mem_wdata <= bus_write_data;
		end
	end

	assign mem_rd = ff_req_rd & ~busy;
	assign mem_wr = ff_req_wr & ~busy;

	// ram data passes straight through in its valid cycle
	assign bus_read_ready = ff_io_ready | mem_rdata_en;
	assign bus_read_data = mem_rdata_en ? mem_rdata : ff_io_data;

endmodule

`default_nettype wire

//--- hdl/mapper_memory.sv
`default_nettype none

module mapper_memory #(
	parameter int seg_bits = tangcart_pkg::default_seg_bits,
	parameter int mem_latency = tangcart_pkg::default_mem_latency
) (
	input  logic clk,
	input  logic w_n_reset,
	input  logic mem_rd,
	input  logic mem_wr,
	input  logic [seg_bits+tangcart_pkg::page_offset_w-1:0] mem_address,
	input  logic [tangcart_pkg::data_w-1:0] mem_wdata,
	output logic busy,
	output logic [tangcart_pkg::data_w-1:0] mem_rdata,
	output logic mem_rdata_en
);

	localparam int addr_bits = seg_bits + tangcart_pkg::page_offset_w;
	// 2^seg_bits segments of 16 KB
	localparam int depth = 2 ** addr_bits;
	localparam int count_w = $clog2(mem_latency + 1);

	logic [tangcart_pkg::data_w-1:0] ram [depth];
	logic [count_w-1:0] ff_count;
	logic ff_rd_op;
	logic accept;

	// the mapper requests only while idle
	assign accept = mem_rd | mem_wr;

	// ----------------------------------------------------------------------
	// access timer
	// ----------------------------------------------------------------------
	// loaded with the latency and busy while nonzero
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_count <= '0;
			ff_rd_op <= 1'b0;
		end else if (accept) begin
			ff_count <= count_w'(mem_latency);
			ff_rd_op <= mem_rd;
		end else if (busy) begin
			ff_count <= ff_count - 1'b1;
		end
	end

	assign busy = (ff_count != '0);
	// last busy cycle of a read carries the data
	assign mem_rdata_en = ff_rd_op && (ff_count == count_w'(1));

	// ----------------------------------------------------------------------
	// ram array
	// ----------------------------------------------------------------------
	// array read at once and the data shown only at the end
	always_ff @(posedge clk) begin
		if (accept && mem_wr) begin
			ram[mem_address] <= mem_wdata;
		end
		if (accept && mem_rd) begin
			mem_rdata <= ram[mem_address];
		end
	end

endmodule

`default_nettype wire

//--- hdl/access_timer.sv
`default_nettype none

module access_timer (
	input  logic clk,
	input  logic w_n_reset,
	input  logic mem_rd,
	input  logic mem_rdata_en,
	output logic [5:0] n_led
);

	logic ff_count_en;
	logic [5:0] ff_count;

	// running from read request to read data
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_count_en <= 1'b0;
		end else if (mem_rd) begin
			ff_count_en <= 1'b1;
		end else if (mem_rdata_en) begin
			ff_count_en <= 1'b0;
		end
	end

	// cleared per read, last value kept for the leds
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_count <= '0;
		end else if (mem_rd) begin
			ff_count <= '0;
		end else if (ff_count_en) begin
			ff_count <= ff_count + 6'd1;
		end
	end

	// leds are active low
	assign n_led = ~ff_count;

endmodule

`default_nettype wire

//--- hdl/tangcart_mapper.sv
`default_nettype none

module tangcart_mapper #(
	parameter int seg_bits = tangcart_pkg::default_seg_bits,
	parameter int mem_latency = tangcart_pkg::default_mem_latency
) (
	input  logic clk,
	input  logic n_treset,
	input  logic n_tsltsl,
	input  logic n_tmerq,
	input  logic n_tiorq,
	input  logic n_trd,
	input  logic n_twr,
	input  logic [tangcart_pkg::addr_w-1:0] ta,
	input  logic [tangcart_pkg::data_w-1:0] td_in,
	output logic [tangcart_pkg::data_w-1:0] td_out,
	output logic td_oe,
	output logic twait,
	output logic [5:0] n_led
);

	logic w_n_reset;
	// bus slave to mapper
	tangcart_pkg::bus_addr_u bus_address;
	logic [tangcart_pkg::data_w-1:0] bus_write_data;
	logic bus_read;
	logic bus_write;
	logic bus_io;
	logic bus_memory;
	logic bus_read_ready;
	logic [tangcart_pkg::data_w-1:0] bus_read_data;
	// mapper to ram
	logic mem_rd;
	logic mem_wr;
	logic [seg_bits+tangcart_pkg::page_offset_w-1:0] mem_address;
	logic [tangcart_pkg::data_w-1:0] mem_wdata;
	logic busy;
	logic [tangcart_pkg::data_w-1:0] mem_rdata;
	logic mem_rdata_en;

	// ----------------------------------------------------------------------
	// reset and cpu wait
	// ----------------------------------------------------------------------
	reset_sync u_reset_sync (
		.clk       (clk),
		.n_treset  (n_treset),
		.w_n_reset (w_n_reset),
		.twait     (twait)
	);

	// ----------------------------------------------------------------------
	// cartridge bus
	// ----------------------------------------------------------------------
	msx_bus_slave u_bus (
		.clk            (clk),
		.w_n_reset      (w_n_reset),
		.n_tsltsl       (n_tsltsl),
		.n_tmerq        (n_tmerq),
		.n_tiorq        (n_tiorq),
		.n_trd          (n_trd),
		.n_twr          (n_twr),
		.ta             (ta),
		.td_in          (td_in),
		.td_out         (td_out),
		.td_oe          (td_oe),
		.bus_address    (bus_address),
		.bus_write_data (bus_write_data),
		.bus_read       (bus_read),
		.bus_write      (bus_write),
		.bus_io         (bus_io),
		.bus_memory     (bus_memory),
		.bus_read_ready (bus_read_ready),
		.bus_read_data  (bus_read_data)
	);

	// ----------------------------------------------------------------------
	// mapper, ram and latency display
	// ----------------------------------------------------------------------
	mapper_regs #(
		.seg_bits (seg_bits)
	) u_mapper (
		.clk            (clk),
		.w_n_reset      (w_n_reset),
		.bus_address    (bus_address),
		.bus_write_data (bus_write_data),
		.bus_read       (bus_read),
		.bus_write      (bus_write),
		.bus_io         (bus_io),
		.bus_memory     (bus_memory),
		.bus_read_ready (bus_read_ready),
		.bus_read_data  (bus_read_data),
		.mem_rd         (mem_rd),
		.mem_wr         (mem_wr),
		.mem_address    (mem_address),
		.mem_wdata      (mem_wdata),
		.busy           (busy),
		.mem_rdata      (mem_rdata),
		.mem_rdata_en   (mem_rdata_en)
	);

	mapper_memory #(
		.seg_bits    (seg_bits),
		.mem_latency (mem_latency)
	) u_memory (
		.clk          (clk),
		.w_n_reset    (w_n_reset),
		.mem_rd       (mem_rd),
		.mem_wr       (mem_wr),
		.mem_address  (mem_address),
		.mem_wdata    (mem_wdata),
		.busy         (busy),
		.mem_rdata    (mem_rdata),
		.mem_rdata_en (mem_rdata_en)
	);

	access_timer u_timer (
		.clk          (clk),
		.w_n_reset    (w_n_reset),
		.mem_rd       (mem_rd),
		.mem_rdata_en (mem_rdata_en),
		.n_led        (n_led)
	);

endmodule

`default_nettype wire

//--- tests/tangcart_mapper_asserts.sv
`default_nettype none

module tangcart_mapper_asserts #(
	parameter int mem_latency = tangcart_pkg::default_mem_latency
) (
	input logic clk,
	input logic w_n_reset,
	input logic bus_read,
	input logic bus_write,
	input logic mem_rd,
	input logic mem_wr,
	input logic busy,
	input logic mem_rdata_en
);

	// failures seen by the testbench at the end of the run
	int assert_errors = 0;

	// ----------------------------------------------------------------------
	// bus pulses
	// ----------------------------------------------------------------------
	// one access kind per pulse
	no_rd_wr_overlap: assert property (@(posedge clk) disable iff (!w_n_reset)
		!(bus_read && bus_write))
	else begin
		$error("bus_read and bus_write high in the same cycle");
		assert_errors++;
	end

	// ----------------------------------------------------------------------
	// ram requests
	// ----------------------------------------------------------------------
	// fixed read latency
	rdata_after_latency: assert property (@(posedge clk) disable iff (!w_n_reset)
		mem_rd |-> ##mem_latency mem_rdata_en)
	else begin
		$error("mem_rdata_en missing %0d cycles after mem_rd", mem_latency);
		assert_errors++;
	end

	// request only while the ram is idle
	no_request_while_busy: assert property (@(posedge clk) disable iff (!w_n_reset)
		(mem_rd || mem_wr) |-> !busy)
	else begin
		$error("memory request issued while busy");
		assert_errors++;
	end

endmodule

bind tangcart_mapper tangcart_mapper_asserts #(
	.mem_latency (mem_latency)
) u_asserts (
	.clk          (clk),
	.w_n_reset    (w_n_reset),
	.bus_read     (bus_read),
	.bus_write    (bus_write),
	.mem_rd       (mem_rd),
	.mem_wr       (mem_wr),
	.busy         (busy),
	.mem_rdata_en (mem_rdata_en)
);

`default_nettype wire

//--- tests/tangcart_mapper_tb.sv
`default_nettype none

module tangcart_mapper_tb;

	localparam int clk_half = 20;
	localparam int seg_bits = tangcart_pkg::default_seg_bits;
	localparam int mem_latency = tangcart_pkg::default_mem_latency;
	// cycles to wait for td_oe
	localparam int read_bound = 100;
	// shorter window when no answer is expected
	localparam int noslot_bound = 20;
	// msx write strobe length in cycles
	localparam int write_hold = 8;

	// access kinds
	localparam logic [2:0] k_io_wr = 3'd0;
	localparam logic [2:0] k_io_rd = 3'd1;
	localparam logic [2:0] k_mem_wr = 3'd2;
	localparam logic [2:0] k_mem_rd = 3'd3;
	localparam logic [2:0] k_mem_rd_noslot = 3'd4;

	typedef struct packed {
		logic [2:0] kind;
		logic [15:0] addr;
		logic [7:0] data;
		logic [7:0] expected;
	} test_t;

	localparam int num_tests = 22;

	// ----------------------------------------------------------------------
	// stimulus table
	// ----------------------------------------------------------------------
	// io reads carry their expected value, memory data comes from the lfsr
	test_t tests [num_tests] = '{
		'{k_io_rd, 16'h00fc, 8'h00, 8'hfb},
		'{k_io_rd, 16'h00fd, 8'h00, 8'hfa},
		'{k_io_rd, 16'h12fe, 8'h00, 8'hf9},
		'{k_io_rd, 16'h00ff, 8'h00, 8'hf8},
		'{k_io_wr, 16'h00fc, 8'h06, 8'h00},
		'{k_io_wr, 16'h00fd, 8'h05, 8'h00},
		'{k_io_wr, 16'h34fe, 8'h05, 8'h00},
		'{k_io_wr, 16'h00ff, 8'h17, 8'h00},
		'{k_io_rd, 16'h00fc, 8'h00, 8'hfe},
		'{k_io_rd, 16'h00fd, 8'h00, 8'hfd},
		'{k_io_rd, 16'h00fe, 8'h00, 8'hfd},
		'{k_io_rd, 16'h00ff, 8'h00, 8'hff},
		'{k_mem_wr, 16'h0010, 8'h00, 8'h00},
		'{k_mem_rd, 16'h0010, 8'h00, 8'h00},
		'{k_mem_wr, 16'h3fff, 8'h00, 8'h00},
		'{k_mem_rd, 16'h3fff, 8'h00, 8'h00},
		// page 1 and page 2 share segment 5
		'{k_mem_wr, 16'h4123, 8'h00, 8'h00},
		'{k_mem_rd, 16'h8123, 8'h00, 8'h00},
		'{k_mem_rd_noslot, 16'hc000, 8'h00, 8'h00},
		'{k_io_rd, 16'h00fc, 8'h00, 8'hfe},
		'{k_mem_wr, 16'hc200, 8'h00, 8'h00},
		'{k_mem_rd, 16'hc200, 8'h00, 8'h00}
	};

	logic clk;
	logic n_treset;
	logic n_tsltsl;
	logic n_tmerq;
	logic n_tiorq;
	logic n_trd;
	logic n_twr;
	logic [15:0] ta;
	logic [7:0] td_in;
	logic [7:0] td_out;
	logic td_oe;
	logic twait;
	logic [5:0] n_led;

	int errors = 0;
	logic [7:0] lfsr_state = 8'd82;
	// reference model of the mapper
	logic [seg_bits-1:0] model_seg [4];
	logic [7:0] model_mem [int];

	tangcart_mapper UUT (
		.clk      (clk),
		.n_treset (n_treset),
		.n_tsltsl (n_tsltsl),
		.n_tmerq  (n_tmerq),
		.n_tiorq  (n_tiorq),
		.n_trd    (n_trd),
		.n_twr    (n_twr),
		.ta       (ta),
		.td_in    (td_in),
		.td_out   (td_out),
		.td_oe    (td_oe),
		.twait    (twait),
		.n_led    (n_led)
	);

	initial clk = 1'b0;
	always #clk_half clk = ~clk;

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	// x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	// one step per data bit
	task automatic next_random_byte(output logic [7:0] b);
		b = '0;
		for (int k = 0; k < 8; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			b = {b[6:0], lfsr_state[0]};
		end
	endtask

	// cpu page swapped for its segment
	function automatic int phys_address(input logic [15:0] addr);
		return (int'(model_seg[addr[15:14]]) << 14) | int'(addr[13:0]);
	endfunction

	function automatic string kind_name(input logic [2:0] k);
		case (k)
			k_io_wr: return "io write";
			k_io_rd: return "io read";
			k_mem_wr: return "mem write";
			k_mem_rd: return "mem read";
			default: return "mem read, slot off";
		endcase
	endfunction

	task automatic release_bus();
		n_tsltsl = 1'b1;
		n_tmerq = 1'b1;
		n_tiorq = 1'b1;
		n_trd = 1'b1;
		n_twr = 1'b1;
	endtask

	// writes have no answer, the strobe has a fixed length
	task automatic write_cycle(input logic is_io, input logic [15:0] addr,
		input logic [7:0] data);
		@(negedge clk);
		ta = addr;
		td_in = data;
		if (is_io) begin
			n_tiorq = 1'b0;
		end else begin
			n_tsltsl = 1'b0;
			n_tmerq = 1'b0;
		end
		n_twr = 1'b0;
		repeat (write_hold) @(negedge clk);
		release_bus();
		repeat (2) @(negedge clk);
	endtask

	// strobe held until td_oe or the bound
	task automatic read_cycle(input logic is_io, input logic slot_sel,
		input logic [15:0] addr, input int bound, output logic [7:0] data,
		output logic answered);
		@(negedge clk);
		ta = addr;
		n_tsltsl = ~slot_sel;
		if (is_io) begin
			n_tiorq = 1'b0;
		end else begin
			n_tmerq = 1'b0;
		end
		n_trd = 1'b0;
		answered = 1'b0;
		for (int n = 0; n < bound; n++) begin
			@(negedge clk);
			if (td_oe) begin
				answered = 1'b1;
				break;
			end
		end
		data = td_out;
		release_bus();
		// td_oe drops once the synchronised rd is high again
		for (int n = 0; n < 8 && td_oe; n++) begin
			@(negedge clk);
		end
		if (td_oe) begin
			$display("td_oe still high at %0t after the read ended", $time);
			errors++;
		end
	endtask

	// ----------------------------------------------------------------------
	// watchdog
	// ----------------------------------------------------------------------
	initial begin
		repeat (num_tests * 200) @(posedge clk);
		$display("timeout: run stopped after %0d cycles", num_tests * 200);
		$display("FAIL: see errors above");
		$finish;
	end

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial begin
		int errors_before;
		test_t t;
		logic [7:0] rdata;
		logic [7:0] wdata;
		logic answered;

		n_treset = 1'b0;
		ta = '0;
		td_in = '0;
		release_bus();
		// segments after reset
		model_seg[0] = 3;
		model_seg[1] = 2;
		model_seg[2] = 1;
		model_seg[3] = 0;

		repeat (4) @(negedge clk);
		n_treset = 1'b1;
		// power-up wait ends on its own
		for (int n = 0; n < 60; n++) begin
			@(negedge clk);
			if (!twait) begin
				break;
			end
		end
		if (twait) begin
			$display("twait did not fall after reset");
			errors++;
		end
		if (n_led !== 6'h3f) begin
			$display("Mismatch at %0t: n_led got %02h expected %02h", $time, n_led, 6'h3f);
			errors++;
		end

		for (int i = 0; i < num_tests; i++) begin
			errors_before = errors;
			t = tests[i];
			case (t.kind)
				k_io_wr: begin
					write_cycle(1'b1, t.addr, t.data);
					// only fch..ffh are mapper ports
					if (t.addr[7:2] == tangcart_pkg::mapper_port_base[7:2]) begin
						model_seg[t.addr[1:0]] = t.data[seg_bits-1:0];
					end
				end
				k_io_rd: begin
					// io ignores the slot select, so it stays high
					read_cycle(1'b1, 1'b0, t.addr, read_bound, rdata, answered);
					if (!answered) begin
						$display("io read of port %02h got no answer", t.addr[7:0]);
						errors++;
					end else if (rdata !== t.expected) begin
						$display("Mismatch at %0t: td_out got %02h expected %02h",
							$time, rdata, t.expected);
						errors++;
					end
				end
				k_mem_wr: begin
					next_random_byte(wdata);
					write_cycle(1'b0, t.addr, wdata);
					model_mem[phys_address(t.addr)] = wdata;
				end
				k_mem_rd: begin
					read_cycle(1'b0, 1'b1, t.addr, read_bound, rdata, answered);
					if (!answered) begin
						$display("memory read of %04h got no answer", t.addr);
						errors++;
					end else if (rdata !== model_mem[phys_address(t.addr)]) begin
						$display("Mismatch at %0t: td_out got %02h expected %02h",
							$time, rdata, model_mem[phys_address(t.addr)]);
						errors++;
					end
					// latency of the last read, inverted
					if (n_led !== ~6'(mem_latency)) begin
						$display("Mismatch at %0t: n_led got %02h expected %02h",
							$time, n_led, ~6'(mem_latency));
						errors++;
					end
				end
				default: begin
					read_cycle(1'b0, 1'b0, t.addr, noslot_bound, rdata, answered);
					if (answered) begin
						$display("td_oe rose for a memory read without slot select");
						errors++;
					end
				end
			endcase
			$display("test %0d %s at %04h: %s", i, kind_name(t.kind), t.addr,
				(errors == errors_before) ? "ok" : "failed");
		end

		$display("%0d tests, %0d errors, %0d assertion failures", num_tests, errors,
			UUT.u_asserts.assert_errors);
		if (errors == 0 && UUT.u_asserts.assert_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tangcart_mapper.f
hdl/tangcart_pkg.sv
hdl/reset_sync.sv
hdl/msx_bus_slave.sv
hdl/mapper_regs.sv
hdl/mapper_memory.sv
hdl/access_timer.sv
hdl/tangcart_mapper.sv
tests/tangcart_mapper_asserts.sv
tests/tangcart_mapper_tb.sv
